// ==== hdl/glb_pkg.sv ====
//====================
// global buffer package
// widths, address fields, register indices and the packet types
//====================
package glb_pkg;

    localparam int NUM_GLB_TILES       = 4;
    localparam int BANK_DATA_WIDTH     = 64;
    localparam int BANK_STRB_WIDTH     = 8;
    localparam int BANK_ADDR_WIDTH     = 8;
    localparam int TILE_SEL_ADDR_WIDTH = 2;
    localparam int STRM_LEN_WIDTH      = 9;

    // processor byte address: byte offset, bank word, tile
    localparam int GLB_ADDR_WIDTH = 13;
    localparam int GLB_WORD_LSB   = 3;
    localparam int GLB_TILE_LSB   = GLB_WORD_LSB + BANK_ADDR_WIDTH;

    // configuration address: register index at 3..2, tile at 9..8
    localparam int CFG_ADDR_WIDTH = 12;
    localparam int CFG_DATA_WIDTH = 32;
    localparam int CFG_REG_LSB    = 2;
    localparam int CFG_REG_WIDTH  = 2;
    localparam int CFG_TILE_LSB   = 8;

    localparam logic [CFG_REG_WIDTH-1:0] CFG_REG_START = 2'd0;
    localparam logic [CFG_REG_WIDTH-1:0] CFG_REG_LEN   = 2'd1;

    typedef logic [TILE_SEL_ADDR_WIDTH-1:0] tile_id_t;

    typedef struct packed {
        logic                       wr_en;
        logic [BANK_STRB_WIDTH-1:0] wr_strb;
        logic [GLB_ADDR_WIDTH-1:0]  wr_addr;
        logic [BANK_DATA_WIDTH-1:0] wr_data;
        logic                       rd_en;
        logic [GLB_ADDR_WIDTH-1:0]  rd_addr;
        logic                       rd_data_valid;
        logic [BANK_DATA_WIDTH-1:0] rd_data;
    } proc_packet_t;

    typedef struct packed {
        logic                       rd_data_valid;
        logic [BANK_DATA_WIDTH-1:0] rd_data;
    } proc_rsp_t;

    typedef struct packed {
        logic                      wr_en;
        logic                      rd_en;
        logic [CFG_ADDR_WIDTH-1:0] addr;
        logic [CFG_DATA_WIDTH-1:0] wr_data;
        logic                      rd_data_valid;
        logic [CFG_DATA_WIDTH-1:0] rd_data;
    } cfg_packet_t;

    typedef struct packed {
        logic                      rd_data_valid;
        logic [CFG_DATA_WIDTH-1:0] rd_data;
    } cfg_rsp_t;

    typedef struct packed {
        logic [BANK_ADDR_WIDTH-1:0] start;
        logic [STRM_LEN_WIDTH-1:0]  len;
    } strm_range_t;

    // same packet with every strobe and valid dropped
    function automatic proc_packet_t proc_idle(proc_packet_t p);
        proc_packet_t q;
        q = p;
        q.wr_en = 1'b0;
        q.rd_en = 1'b0;
        q.rd_data_valid = 1'b0;
        return q;
    endfunction

    function automatic cfg_packet_t cfg_idle(cfg_packet_t p);
        cfg_packet_t q;
        q = p;
        q.wr_en = 1'b0;
        q.rd_en = 1'b0;
        q.rd_data_valid = 1'b0;
        return q;
    endfunction

endpackage

// ==== hdl/glb_bank.sv ====
//====================
// glb bank
// single-port sram bank, byte strobed writes, registered read
//====================
module glb_bank (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wr_en,
    input  logic                                rd_en,
    input  logic [glb_pkg::BANK_STRB_WIDTH-1:0] wr_strb,
    input  logic [glb_pkg::BANK_ADDR_WIDTH-1:0] addr,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] wr_data,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] rd_data
);
    import glb_pkg::*;

    localparam int BYTE_W = BANK_DATA_WIDTH / BANK_STRB_WIDTH;

    logic [BANK_DATA_WIDTH-1:0] mem [2**BANK_ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                if (wr_strb[b]) begin
                    mem[addr][b*BYTE_W +: BYTE_W] <= wr_data[b*BYTE_W +: BYTE_W];
                end
            end
        end
        // data shows up the cycle after rd_en
        if (rd_en) begin
            rd_data <= mem[addr];
        end
    end

    // tile arbitration must keep the stream off the port during processor writes
    a_single_port : assert property (
        @(posedge clk) disable iff (rst) !(wr_en && rd_en)
    );

endmodule

// ==== hdl/glb_cfg_regs.sv ====
//====================
// glb config registers
// per-tile stream start and length, written and read over the cfg chain
//====================
module glb_cfg_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  glb_pkg::tile_id_t     tile_id,
    input  glb_pkg::cfg_packet_t  cfg_in,
    output glb_pkg::cfg_packet_t  cfg_out,
    output glb_pkg::strm_range_t  range
);
    import glb_pkg::*;

    logic                       cfg_hit;
    logic [CFG_REG_WIDTH-1:0]   reg_idx;
    logic [BANK_ADDR_WIDTH-1:0] start_q;
    logic [STRM_LEN_WIDTH-1:0]  len_q;
    logic [CFG_DATA_WIDTH-1:0]  rd_word;
    cfg_packet_t                cfg_next;

    assign cfg_hit = (cfg_in.addr[CFG_TILE_LSB +: TILE_SEL_ADDR_WIDTH] == tile_id);
    assign reg_idx = cfg_in.addr[CFG_REG_LSB +: CFG_REG_WIDTH];

    assign range.start = start_q;
    assign range.len   = len_q;

    always_comb begin
        // unused indices read as zero
        case (reg_idx)
            CFG_REG_START: rd_word = CFG_DATA_WIDTH'(start_q);
            CFG_REG_LEN:   rd_word = CFG_DATA_WIDTH'(len_q);
            default:       rd_word = '0;
        endcase
        cfg_next = cfg_in;
        if (cfg_in.rd_en && cfg_hit) begin
            cfg_next.rd_data_valid = 1'b1;
            cfg_next.rd_data = rd_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            start_q <= '0;
            len_q <= '0;
        end else if (cfg_in.wr_en && cfg_hit) begin
            if (reg_idx == CFG_REG_START) begin
                start_q <= cfg_in.wr_data[BANK_ADDR_WIDTH-1:0];
            end else if (reg_idx == CFG_REG_LEN) begin
                len_q <= cfg_in.wr_data[STRM_LEN_WIDTH-1:0];
            end
        end
    end

    // one register stage going east
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_out <= cfg_idle(cfg_next);
        end else begin
            cfg_out <= cfg_next;
        end
    end

    a_cfg_one_op : assert property (
        @(posedge clk) disable iff (rst) !(cfg_in.wr_en && cfg_in.rd_en)
    );

endmodule

// ==== hdl/glb_strm_rd.sv ====
//====================
// glb stream reader
// walks the configured word range and flags end of stream
//====================
module glb_strm_rd (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  glb_pkg::strm_range_t                range,
    input  logic                                port_free,
    output logic                                rd_en,
    output logic [glb_pkg::BANK_ADDR_WIDTH-1:0] rd_addr,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] rd_data,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] data,
    output logic                                data_valid,
    output logic                                done
);
    import glb_pkg::*;

    logic                       busy;
    logic [BANK_ADDR_WIDTH-1:0] addr_q;
    logic [STRM_LEN_WIDTH-1:0]  left_q;
    logic                       rd_last;
    logic                       last_q;
    logic                       empty_start;

    // processor owns the port whenever it hits this tile
    assign rd_en   = busy && port_free;
    assign rd_addr = addr_q;
    assign rd_last = rd_en && (left_q == STRM_LEN_WIDTH'(1));

    // zero length, done without any words
    assign empty_start = start && (range.len == '0);

    // bank output is only meaningful on valid cycles
    assign data = data_valid ? rd_data : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            data_valid <= 1'b0;
            last_q <= 1'b0;
            done <= 1'b0;
        end else begin
            data_valid <= rd_en;
            last_q <= rd_last;
            done <= last_q || empty_start;
            if (start && !empty_start) begin
                busy <= 1'b1;
            end else if (rd_last) begin
                busy <= 1'b0;
            end
        end
    end

    // address wraps at the bank boundary
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= range.start;
            left_q <= range.len;
        end else if (rd_en) begin
            addr_q <= addr_q + 1'b1;
            left_q <= left_q - 1'b1;
        end
    end

    a_no_restart : assert property (
        @(posedge clk) disable iff (rst) !(start && busy)
    );

endmodule

// ==== hdl/glb_tile.sv ====
//====================
// glb tile
// routes proc and cfg packets, arbitrates the bank, relays pulses
//====================
module glb_tile (
    input  logic                                clk,
    input  logic                                rst,
    input  glb_pkg::tile_id_t                   tile_id,

    input  glb_pkg::proc_packet_t               proc_w2e_wsti,
    output glb_pkg::proc_packet_t               proc_w2e_esto,
    input  glb_pkg::proc_packet_t               proc_e2w_esti,
    output glb_pkg::proc_packet_t               proc_e2w_wsto,

    input  glb_pkg::cfg_packet_t                cfg_w2e_wsti,
    output glb_pkg::cfg_packet_t                cfg_w2e_esto,
    input  glb_pkg::cfg_packet_t                cfg_e2w_esti,
    output glb_pkg::cfg_packet_t                cfg_e2w_wsto,

    input  logic [glb_pkg::NUM_GLB_TILES-1:0]   strm_start_wsti,
    output logic [glb_pkg::NUM_GLB_TILES-1:0]   strm_start_esto,
    input  logic [glb_pkg::NUM_GLB_TILES-1:0]   interrupt_esti,
    output logic [glb_pkg::NUM_GLB_TILES-1:0]   interrupt_wsto,

    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] stream_data_g2f,
    output logic                                stream_data_valid_g2f
);
    import glb_pkg::*;

    proc_packet_t               proc_s1;
    proc_packet_t               proc_merge;
    logic                       proc_wr_hit;
    logic                       proc_rd_hit;
    logic                       proc_rd_hit_q;
    logic                       bank_wr_en;
    logic                       bank_rd_en;
    logic [BANK_ADDR_WIDTH-1:0] bank_addr;
    logic [BANK_DATA_WIDTH-1:0] bank_rd_data;
    logic                       strm_rd_en;
    logic [BANK_ADDR_WIDTH-1:0] strm_rd_addr;
    logic                       strm_done;
    strm_range_t                strm_range;

    // stage one: hit decode on the incoming packet
    assign proc_wr_hit = proc_w2e_wsti.wr_en
        && (proc_w2e_wsti.wr_addr[GLB_TILE_LSB +: TILE_SEL_ADDR_WIDTH] == tile_id);
    assign proc_rd_hit = proc_w2e_wsti.rd_en
        && (proc_w2e_wsti.rd_addr[GLB_TILE_LSB +: TILE_SEL_ADDR_WIDTH] == tile_id);

    always_comb begin
        bank_wr_en = proc_wr_hit;
        bank_rd_en = proc_rd_hit || strm_rd_en;
        if (proc_wr_hit) begin
            bank_addr = proc_w2e_wsti.wr_addr[GLB_WORD_LSB +: BANK_ADDR_WIDTH];
        end else if (proc_rd_hit) begin
            bank_addr = proc_w2e_wsti.rd_addr[GLB_WORD_LSB +: BANK_ADDR_WIDTH];
        end else begin
            bank_addr = strm_rd_addr;
        end
    end

    // stage two: fold bank data into the packet
    always_comb begin
        proc_merge = proc_s1;
        if (proc_rd_hit_q) begin
            proc_merge.rd_data_valid = 1'b1;
            proc_merge.rd_data = bank_rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            proc_s1 <= proc_idle(proc_w2e_wsti);
            proc_w2e_esto <= proc_idle(proc_merge);
            proc_e2w_wsto <= proc_idle(proc_e2w_esti);
            cfg_e2w_wsto <= cfg_idle(cfg_e2w_esti);
            proc_rd_hit_q <= 1'b0;
            strm_start_esto <= '0;
            interrupt_wsto <= '0;
        end else begin
            proc_s1 <= proc_w2e_wsti;
            proc_w2e_esto <= proc_merge;
            proc_e2w_wsto <= proc_e2w_esti;
            cfg_e2w_wsto <= cfg_e2w_esti;
            proc_rd_hit_q <= proc_rd_hit;
            strm_start_esto <= strm_start_wsti;
            // own end-of-stream pulse joins the westbound vector
            interrupt_wsto <= interrupt_esti | (NUM_GLB_TILES'(strm_done) << tile_id);
        end
    end

    glb_bank u_glb_bank (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (bank_wr_en),
        .rd_en   (bank_rd_en),
        .wr_strb (proc_w2e_wsti.wr_strb),
        .addr    (bank_addr),
        .wr_data (proc_w2e_wsti.wr_data),
        .rd_data (bank_rd_data)
    );

    glb_cfg_regs u_glb_cfg_regs (
        .clk     (clk),
        .rst     (rst),
        .tile_id (tile_id),
        .cfg_in  (cfg_w2e_wsti),
        .cfg_out (cfg_w2e_esto),
        .range   (strm_range)
    );

    // start taken from the registered copy of our own bit
    glb_strm_rd u_glb_strm_rd (
        .clk        (clk),
        .rst        (rst),
        .start      (strm_start_esto[tile_id]),
        .range      (strm_range),
        .port_free  (!(proc_wr_hit || proc_rd_hit)),
        .rd_en      (strm_rd_en),
        .rd_addr    (strm_rd_addr),
        .rd_data    (bank_rd_data),
        .data       (stream_data_g2f),
        .data_valid (stream_data_valid_g2f),
        .done       (strm_done)
    );

endmodule

// ==== hdl/global_buffer.sv ====
//====================
// global buffer
// west-to-east chain of tiles, turned around at the east end
//====================
module global_buffer (
    input  logic                                clk,
    input  logic                                rst,
    input  glb_pkg::proc_packet_t               proc_req,
    output glb_pkg::proc_rsp_t                  proc_rsp,
    input  glb_pkg::cfg_packet_t                cfg_req,
    output glb_pkg::cfg_rsp_t                   cfg_rsp,
    input  logic [glb_pkg::NUM_GLB_TILES-1:0]   strm_start_pulse,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] stream_data_g2f [glb_pkg::NUM_GLB_TILES],
    output logic [glb_pkg::NUM_GLB_TILES-1:0]   stream_data_valid_g2f,
    output logic [glb_pkg::NUM_GLB_TILES-1:0]   interrupt_pulse
);
    import glb_pkg::*;

    // element i is the west side of tile i, element N the east end
    proc_packet_t             proc_w2e [NUM_GLB_TILES+1];
    proc_packet_t             proc_e2w [NUM_GLB_TILES+1];
    cfg_packet_t              cfg_w2e [NUM_GLB_TILES+1];
    cfg_packet_t              cfg_e2w [NUM_GLB_TILES+1];
    logic [NUM_GLB_TILES-1:0] strm_start [NUM_GLB_TILES+1];
    logic [NUM_GLB_TILES-1:0] intr [NUM_GLB_TILES+1];
    proc_packet_t             proc_west;
    cfg_packet_t              cfg_west;

    // response fields start empty at the west port
    always_comb begin
        proc_west = proc_req;
        proc_west.rd_data_valid = 1'b0;
        proc_west.rd_data = '0;
        cfg_west = cfg_req;
        cfg_west.rd_data_valid = 1'b0;
        cfg_west.rd_data = '0;
    end

    assign proc_w2e[0]   = proc_west;
    assign cfg_w2e[0]    = cfg_west;
    assign strm_start[0] = strm_start_pulse;

    // east end turn-around
    assign proc_e2w[NUM_GLB_TILES] = proc_w2e[NUM_GLB_TILES];
    assign cfg_e2w[NUM_GLB_TILES]  = cfg_w2e[NUM_GLB_TILES];
    assign intr[NUM_GLB_TILES]     = '0;

    assign proc_rsp.rd_data_valid = proc_e2w[0].rd_data_valid;
    assign proc_rsp.rd_data       = proc_e2w[0].rd_data;
    assign cfg_rsp.rd_data_valid  = cfg_e2w[0].rd_data_valid;
    assign cfg_rsp.rd_data        = cfg_e2w[0].rd_data;
    assign interrupt_pulse        = intr[0];

    for (genvar i = 0; i < NUM_GLB_TILES; i++) begin : g_tile
        glb_tile u_glb_tile (
            .clk                   (clk),
            .rst                   (rst),
            .tile_id               (tile_id_t'(i)),
            .proc_w2e_wsti         (proc_w2e[i]),
            .proc_w2e_esto         (proc_w2e[i+1]),
            .proc_e2w_esti         (proc_e2w[i+1]),
            .proc_e2w_wsto         (proc_e2w[i]),
            .cfg_w2e_wsti          (cfg_w2e[i]),
            .cfg_w2e_esto          (cfg_w2e[i+1]),
            .cfg_e2w_esti          (cfg_e2w[i+1]),
            .cfg_e2w_wsto          (cfg_e2w[i]),
            .strm_start_wsti       (strm_start[i]),
            .strm_start_esto       (strm_start[i+1]),
            .interrupt_esti        (intr[i+1]),
            .interrupt_wsto        (intr[i]),
            .stream_data_g2f       (stream_data_g2f[i]),
            .stream_data_valid_g2f (stream_data_valid_g2f[i])
        );
    end

endmodule

// ==== bench/tb_global_buffer.sv ====
//====================
// global buffer testbench
// random proc, cfg and stream traffic checked against a reference model
//====================
module tb_global_buffer;
    timeunit 1ns;
    timeprecision 1ps;
    import glb_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 20;
    localparam int FILL_CYCLES  = NUM_GLB_TILES * 256;
    localparam int N_WRITES     = 300;
    localparam int N_READS      = 300;
    localparam int N_CFG        = 150;
    localparam int N_CONTEND    = 40;
    // two stream rounds of config writes, up to 20 words, contention reads and drain
    localparam int STRM_CYCLES  = 2 * (2 * NUM_GLB_TILES + 20 + N_CONTEND + 40);
    localparam int TIMEOUT      = 2 * (RESET_CYCLES + IDLE_CYCLES + FILL_CYCLES + N_WRITES
                                  + N_READS + N_CFG + STRM_CYCLES) + 200;
    localparam int PROC_LAT     = 3 * NUM_GLB_TILES;
    localparam int CFG_LAT      = 2 * NUM_GLB_TILES;

    logic                       clk = 1'b0;
    logic                       rst;
    proc_packet_t               proc_req;
    proc_rsp_t                  proc_rsp;
    cfg_packet_t                cfg_req;
    cfg_rsp_t                   cfg_rsp;
    logic [NUM_GLB_TILES-1:0]   strm_start_pulse;
    logic [BANK_DATA_WIDTH-1:0] stream_data_g2f [NUM_GLB_TILES];
    logic [NUM_GLB_TILES-1:0]   stream_data_valid_g2f;
    logic [NUM_GLB_TILES-1:0]   interrupt_pulse;

    integer seed;
    int     cycle = 0;
    int     err_proc;
    int     err_cfg;
    int     err_strm;
    int     err_intr;
    int     err_misc;
    logic   idle_check;

    // reference model
    logic [BANK_DATA_WIDTH-1:0] model_mem [NUM_GLB_TILES][256];
    logic [7:0]                 model_start [NUM_GLB_TILES];
    logic [8:0]                 model_len [NUM_GLB_TILES];
    logic [BANK_DATA_WIDTH-1:0] exp_rd_q [$];
    int                         exp_rd_cyc [$];
    logic [CFG_DATA_WIDTH-1:0]  exp_cfg_q [$];
    int                         exp_cfg_cyc [$];
    logic [BANK_DATA_WIDTH-1:0] exp_strm_q [NUM_GLB_TILES][$];
    logic [NUM_GLB_TILES-1:0]   strm_pending;

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    global_buffer u_global_buffer (
        .clk                   (clk),
        .rst                   (rst),
        .proc_req              (proc_req),
        .proc_rsp              (proc_rsp),
        .cfg_req               (cfg_req),
        .cfg_rsp               (cfg_rsp),
        .strm_start_pulse      (strm_start_pulse),
        .stream_data_g2f       (stream_data_g2f),
        .stream_data_valid_g2f (stream_data_valid_g2f),
        .interrupt_pulse       (interrupt_pulse)
    );

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // pattern built from the whole tile and word address
    function automatic logic [BANK_DATA_WIDTH-1:0] fill_word(input int t, input int w);
        logic [15:0] a;
        a = 16'(t * 256 + w);
        return {a ^ 16'ha5c3, a ^ 16'h3c5a, ~a, a};
    endfunction

    function automatic logic [11:0] cfg_addr(input int t, input int idx);
        logic [31:0] r;
        logic [11:0] a;
        r = next_random();
        a = r[11:0];
        a[9:8] = 2'(t);
        a[3:2] = 2'(idx);
        return a;
    endfunction

    task automatic finish_run();
        $display("errors: proc %0d cfg %0d stream %0d interrupt %0d other %0d",
                 err_proc, err_cfg, err_strm, err_intr, err_misc);
        if (err_proc + err_cfg + err_strm + err_intr + err_misc == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic check_proc_rsp(input proc_rsp_t rsp);
        logic [BANK_DATA_WIDTH-1:0] expected;
        int                         issued;
        if (exp_rd_q.size() == 0) begin
            err_proc++;
            $display("read response at cycle %0d with no read outstanding", cycle);
        end else begin
            expected = exp_rd_q.pop_front();
            issued = exp_rd_cyc.pop_front();
            if (rsp.rd_data !== expected) begin
                err_proc++;
                $display("error proc_rsp.rd_data exp %h got %h", expected, rsp.rd_data);
            end
            if (cycle - issued != PROC_LAT) begin
                err_proc++;
                $display("read returned %0d cycles after issue, not %0d",
                         cycle - issued, PROC_LAT);
            end
        end
    endtask

    task automatic check_cfg_rsp(input cfg_rsp_t rsp);
        logic [CFG_DATA_WIDTH-1:0] expected;
        int                        issued;
        if (exp_cfg_q.size() == 0) begin
            err_cfg++;
            $display("config response at cycle %0d with no read outstanding", cycle);
        end else begin
            expected = exp_cfg_q.pop_front();
            issued = exp_cfg_cyc.pop_front();
            if (rsp.rd_data !== expected) begin
                err_cfg++;
                $display("error cfg_rsp.rd_data exp %h got %h", expected, rsp.rd_data);
            end
            if (cycle - issued != CFG_LAT) begin
                err_cfg++;
                $display("config read returned %0d cycles after issue, not %0d",
                         cycle - issued, CFG_LAT);
            end
        end
    endtask

    task automatic check_strm_word(input int tile, input logic [BANK_DATA_WIDTH-1:0] word);
        logic [BANK_DATA_WIDTH-1:0] expected;
        if (exp_strm_q[tile].size() == 0) begin
            err_strm++;
            $display("tile %0d streamed a word beyond its configured length", tile);
        end else begin
            expected = exp_strm_q[tile].pop_front();
            if (word !== expected) begin
                err_strm++;
                $display("error stream_data_g2f[%0d] exp %h got %h", tile, expected, word);
            end
        end
    endtask

    // a pulse is allowed only once per start and only after the last word
    task automatic check_interrupt(input logic [NUM_GLB_TILES-1:0] vec);
        logic [NUM_GLB_TILES-1:0] allowed;
        allowed = '0;
        for (int k = 0; k < NUM_GLB_TILES; k++) begin
            allowed[k] = strm_pending[k] && (exp_strm_q[k].size() == 0);
        end
        if ((vec & ~allowed) != '0) begin
            err_intr++;
            $display("error interrupt_pulse allowed %h got %h", allowed, vec);
        end
        strm_pending = strm_pending & ~vec;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (idle_check && (proc_rsp.rd_data_valid !== 1'b0 || cfg_rsp.rd_data_valid !== 1'b0
                    || stream_data_valid_g2f !== '0 || interrupt_pulse !== '0)) begin
                err_misc++;
                $display("outputs not idle after reset at cycle %0d", cycle);
            end
            if (proc_rsp.rd_data_valid) begin
                check_proc_rsp(proc_rsp);
            end
            if (cfg_rsp.rd_data_valid) begin
                check_cfg_rsp(cfg_rsp);
            end
            for (int k = 0; k < NUM_GLB_TILES; k++) begin
                if (stream_data_valid_g2f[k]) begin
                    check_strm_word(k, stream_data_g2f[k]);
                end
            end
            check_interrupt(interrupt_pulse);
        end
    end

    task automatic drive_cycle(input proc_packet_t p, input cfg_packet_t c,
                               input logic [NUM_GLB_TILES-1:0] start);
        @(posedge clk);
        proc_req <= p;
        cfg_req <= c;
        strm_start_pulse <= start;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle('0, '0, '0);
    endtask

    // reads and start pulses that reset must swallow
    task automatic drive_reset_traffic();
        logic [31:0]  r;
        proc_packet_t p;
        cfg_packet_t  c;
        r = next_random();
        p = '0;
        p.rd_en = 1'b1;
        p.rd_addr = r[12:0];
        c = '0;
        c.rd_en = 1'b1;
        c.addr = r[27:16];
        drive_cycle(p, c, '1);
    endtask

    task automatic proc_write(input logic [12:0] addr, input logic [7:0] strb,
                              input logic [BANK_DATA_WIDTH-1:0] data);
        proc_packet_t p;
        p = '0;
        p.wr_en = 1'b1;
        p.wr_strb = strb;
        p.wr_addr = addr;
        p.wr_data = data;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                model_mem[int'(addr[12:11])][int'(addr[10:3])][b*8 +: 8] = data[b*8 +: 8];
            end
        end
        drive_cycle(p, '0, '0);
    endtask

    task automatic proc_read(input logic [12:0] addr);
        proc_packet_t p;
        p = '0;
        p.rd_en = 1'b1;
        p.rd_addr = addr;
        drive_cycle(p, '0, '0);
        exp_rd_q.push_back(model_mem[int'(addr[12:11])][int'(addr[10:3])]);
        exp_rd_cyc.push_back(cycle + 1);
    endtask

    task automatic cfg_write(input int t, input int idx, input logic [31:0] data);
        cfg_packet_t c;
        c = '0;
        c.wr_en = 1'b1;
        c.addr = cfg_addr(t, idx);
        c.wr_data = data;
        if (idx == 0) begin
            model_start[t] = data[7:0];
        end else if (idx == 1) begin
            model_len[t] = data[8:0];
        end
        drive_cycle('0, c, '0);
    endtask

    task automatic cfg_read(input int t, input int idx);
        cfg_packet_t c;
        c = '0;
        c.rd_en = 1'b1;
        c.addr = cfg_addr(t, idx);
        drive_cycle('0, c, '0);
        case (idx)
            0: exp_cfg_q.push_back(32'(model_start[t]));
            1: exp_cfg_q.push_back(32'(model_len[t]));
            default: exp_cfg_q.push_back('0);
        endcase
        exp_cfg_cyc.push_back(cycle + 1);
    endtask

    task automatic set_stream_ranges(input logic [NUM_GLB_TILES-1:0] zero_len);
        logic [31:0] r;
        int          len;
        for (int k = 0; k < NUM_GLB_TILES; k++) begin
            r = next_random();
            len = zero_len[k] ? 0 : 1 + int'(r[15:0] % 16'd20);
            cfg_write(k, 0, 32'(r[23:16]));
            cfg_write(k, 1, 32'(len));
        end
    endtask

    // expected words come from the model at start and wrap at the bank end
    task automatic start_streams(input logic [NUM_GLB_TILES-1:0] mask);
        for (int k = 0; k < NUM_GLB_TILES; k++) begin
            if (mask[k]) begin
                for (int i = 0; i < int'(model_len[k]); i++) begin
                    exp_strm_q[k].push_back(model_mem[k][(int'(model_start[k]) + i) % 256]);
                end
            end
        end
        strm_pending = strm_pending | mask;
        drive_cycle('0, '0, mask);
    endtask

    task automatic wait_quiet();
        while (exp_rd_q.size() != 0 || exp_cfg_q.size() != 0 || strm_pending != '0) begin
            drive_cycle('0, '0, '0);
        end
        idle_cycles(4);
    endtask

    initial begin : watchdog
        while (cycle < TIMEOUT) begin
            @(posedge clk);
        end
        err_misc++;
        $display("timeout, run stopped after %0d cycles", cycle);
        finish_run();
    end

    initial begin : main_seq
        logic [31:0] r;
        seed = 32'h796f;
        err_proc = 0;
        err_cfg = 0;
        err_strm = 0;
        err_intr = 0;
        err_misc = 0;
        idle_check = 1'b0;
        strm_pending = '0;
        for (int t = 0; t < NUM_GLB_TILES; t++) begin
            model_start[t] = '0;
            model_len[t] = '0;
        end
        rst = 1'b1;
        proc_req = '0;
        cfg_req = '0;
        strm_start_pulse = '0;
        repeat (RESET_CYCLES - 1) begin
            drive_reset_traffic();
        end
        drive_cycle('0, '0, '0);
        rst <= 1'b0;

        idle_check = 1'b1;
        idle_cycles(IDLE_CYCLES);
        idle_check = 1'b0;

        // known contents so every later read and stream word is defined
        for (int t = 0; t < NUM_GLB_TILES; t++) begin
            for (int w = 0; w < 256; w++) begin
                proc_write(13'(t * 2048 + w * 8), 8'hff, fill_word(t, w));
            end
        end
        repeat (N_WRITES) begin
            r = next_random();
            proc_write(r[12:0], r[20:13], {next_random(), next_random()});
        end
        repeat (N_READS) begin
            r = next_random();
            proc_read(r[12:0]);
        end
        wait_quiet();

        // register indices 2 and 3 are unused
        repeat (N_CFG) begin
            r = next_random();
            if (r[0]) begin
                cfg_write(int'(r[2:1]), int'(r[4:3]), next_random());
            end else begin
                cfg_read(int'(r[2:1]), int'(r[4:3]));
            end
        end
        wait_quiet();

        set_stream_ranges('0);
        idle_cycles(4);
        start_streams('1);
        wait_quiet();

        // tile 0 left empty while reads steal bank cycles from the others
        set_stream_ranges(4'b0001);
        idle_cycles(4);
        start_streams('1);
        repeat (N_CONTEND) begin
            r = next_random();
            proc_read({2'(1 + int'(r[15:0] % 16'd3)), r[26:16]});
        end
        wait_quiet();

        for (int k = 0; k < NUM_GLB_TILES; k++) begin
            if (exp_strm_q[k].size() != 0) begin
                err_strm++;
                $display("tile %0d still owes %0d stream words", k, exp_strm_q[k].size());
            end
        end
        finish_run();
    end

endmodule

// ==== files.f ====
hdl/glb_pkg.sv
hdl/glb_bank.sv
hdl/glb_cfg_regs.sv
hdl/glb_strm_rd.sv
hdl/glb_tile.sv
hdl/global_buffer.sv
bench/tb_global_buffer.sv

// ==== Makefile ====
# global buffer simulation with Verilator

.PHONY: all build lint clean

all: build
	./obj_dir/Vtb_global_buffer | tee sim.log
	grep -q "RESULT: PASS" sim.log

build:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_global_buffer -f files.f

lint:
	verilator --lint-only --timing -Wall --top-module global_buffer -f files.f

clean:
	rm -rf obj_dir sim.log
